// File: dv/cu_tb.sv
// FIFO emptiness and BRAM valid are random from a fixed LCG seed
// expected pulse counts come from the layer rules and are checked per layer
`timescale 1ns/10ps
module cu_tb;
    localparam int          CH_BITS    = 12;
    localparam int          DIM_BITS   = 9;
    localparam int          NUM_LAYERS = 8;
    localparam logic [31:0] SEED       = 32'hb888_65a1;

    logic                clk;
    logic                rst_n;
    logic [31:0]         ctrl0_i;
    logic [31:0]         ctrl1_i;
    logic [31:0]         ctrl2_i;
    logic                weight_write_done_i;
    logic                output_done_i;
    logic                ifmap_fifo_empty_i;
    logic                weight_valid_i;
    cu_isa_pkg::status_e status_o;
    logic                axis_en_o;
    logic                axis_clear_o;
    logic [CH_BITS-1:0]  in_channels_o;
    logic                layer_finish_o;
    logic                load_ifmaps_o;
    logic                load_weight_preload_o;
    logic                load_weight_o;
    logic                weight_bram_write_en_o;
    logic                weight_bram_write_start_o;
    logic                weight_bram_load_start_o;
    logic                weight_bram_add1_o;
    logic                weight_bram_add2_o;
    logic                weight_bram_port_sel_o;

    logic [31:0] rng;
    int          cfg_kernel [NUM_LAYERS];
    int          cfg_stride [NUM_LAYERS];
    int          cfg_dim [NUM_LAYERS];
    int          cfg_och [NUM_LAYERS];
    int          write_wait;
    int          watchdog_cycles = 0;
    int          ifmap_cnt;
    int          weight_cnt;
    int          preload_cnt;
    int          finish_cnt;
    int          wstart_cnt;
    int          lstart_cnt;
    int          add1_cnt;
    int          add2_cnt;
    int          psel_cnt;

    cu_top #(
        .CH_BITS  (CH_BITS),
        .DIM_BITS (DIM_BITS)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // random numbers and checks
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // low bits of an LCG repeat quickly so only the upper half is used
    function int rand_below(input int n);
        rng = lcg_step(rng);
        return int'(rng[31:16]) % n;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            report_failure($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_status(input string name, input cu_isa_pkg::status_e exp,
                                input cu_isa_pkg::status_e act);
        if (exp !== act) begin
            report_failure($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // all load and start strobes quiet
    task automatic check_idle(input string name);
        check_level({name, " load_ifmaps"}, 1'b0, load_ifmaps_o);
        check_level({name, " load_weight"}, 1'b0, load_weight_o);
        check_level({name, " load_weight_preload"}, 1'b0, load_weight_preload_o);
        check_level({name, " bram load start"}, 1'b0, weight_bram_load_start_o);
        check_level({name, " bram write start"}, 1'b0, weight_bram_write_start_o);
    endtask

    // returns 2 ns after the edge where inputs change
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic clear_counts();
        ifmap_cnt   = 0;
        weight_cnt  = 0;
        preload_cnt = 0;
        finish_cnt  = 0;
        wstart_cnt  = 0;
        lstart_cnt  = 0;
        add1_cnt    = 0;
        add2_cnt    = 0;
        psel_cnt    = 0;
    endtask

    // pulse counters sample before the edge updates anything
    always @(posedge clk) begin
        ifmap_cnt   <= ifmap_cnt + int'(load_ifmaps_o);
        weight_cnt  <= weight_cnt + int'(load_weight_o);
        preload_cnt <= preload_cnt + int'(load_weight_preload_o);
        finish_cnt  <= finish_cnt + int'(layer_finish_o);
        wstart_cnt  <= wstart_cnt + int'(weight_bram_write_start_o);
        lstart_cnt  <= lstart_cnt + int'(weight_bram_load_start_o);
        add1_cnt    <= add1_cnt + int'(weight_bram_add1_o);
        add2_cnt    <= add2_cnt + int'(weight_bram_add2_o);
        psel_cnt    <= psel_cnt + int'(weight_bram_port_sel_o);
    end

    ////////////////////////////////////////
    // instruction sequences
    ////////////////////////////////////////
    task automatic start_layer(input int idx);
        ctrl1_i = (32'(cfg_stride[idx]) << cu_isa_pkg::STRIDE_LSB) |
                  (32'(cfg_dim[idx]) << cu_isa_pkg::DIM_LSB);
        ctrl2_i = 32'd1 << (cfg_kernel[idx] - 1);
        ctrl0_i = (32'(cfg_och[idx]) << cu_isa_pkg::OUT_CH_LSB) |
                  (32'(idx + 3) << cu_isa_pkg::IN_CH_LSB) | 32'(cu_isa_pkg::OP_COMPUTE);
    endtask

    task automatic run_weight_write();
        clear_counts();
        ctrl0_i = 32'(cu_isa_pkg::OP_WRITE_WEIGHT);
        repeat (write_wait) begin
            wait_cycles(1);
            check_level("write enable before done", 1'b1, weight_bram_write_en_o);
            check_level("axis enable during write", 1'b1, axis_en_o);
        end
        weight_write_done_i = 1'b1;
        wait_cycles(1);
        weight_write_done_i = 1'b0;
        check_status("weight done status", cu_isa_pkg::ST_WEIGHT_DONE, status_o);
        check_level("axis clear after write done", 1'b1, axis_clear_o);
        wait_cycles(3);
        check_level("write enable held in finish", 1'b1, weight_bram_write_en_o);
        check_count("write start pulses", 1, wstart_cnt);
        ctrl0_i = '0;
        wait_cycles(1);
        check_level("write enable after opcode clear", 1'b0, weight_bram_write_en_o);
        check_level("axis enable after write", 1'b0, axis_en_o);
    endtask

    // withdraw the opcode once the first filter is loaded
    task automatic run_abort(input int idx);
        clear_counts();
        start_layer(idx);
        wait_cycles(1);
        check_status("abort edge clears status", cu_isa_pkg::ST_CLEAR, status_o);
        while (weight_cnt == 0) begin
            wait_cycles(1);
        end
        ctrl0_i = '0;
        wait_cycles(1);
        check_idle("after abort");
        check_level("axis enable held after abort", 1'b1, axis_en_o);
        wait_cycles(2);
    endtask

    task automatic run_layer(input int idx);
        int k;
        int dim;
        int exp_loads;
        int exp_weights;
        k           = cfg_kernel[idx];
        dim         = cfg_dim[idx];
        exp_loads   = dim * (k + (dim - 1) * cfg_stride[idx]);
        exp_weights = dim * dim * cfg_och[idx];
        clear_counts();
        start_layer(idx);
        wait_cycles(1);
        check_status($sformatf("layer %0d edge clears status", idx),
                     cu_isa_pkg::ST_CLEAR, status_o);
        check_count($sformatf("layer %0d in-channels", idx), idx + 3, int'(in_channels_o));
        while (finish_cnt == 0) begin
            check_level($sformatf("layer %0d axis enable", idx), 1'b1, axis_en_o);
            wait_cycles(1);
        end
        // last load_weight pulse trails the finish by a cycle
        wait_cycles(3);
        check_count($sformatf("layer %0d ifmap loads", idx), exp_loads, ifmap_cnt);
        check_count($sformatf("layer %0d weight loads", idx), exp_weights, weight_cnt);
        check_count($sformatf("layer %0d weight preloads", idx), exp_weights * k, preload_cnt);
        check_count($sformatf("layer %0d finish pulses", idx), 1, finish_cnt);
        // one read start per window, a pair step per two words, a single step per odd word
        check_count($sformatf("layer %0d bram load starts", idx), dim * dim, lstart_cnt);
        check_count($sformatf("layer %0d bram add2 pulses", idx), exp_weights * (k / 2),
                    add2_cnt);
        check_count($sformatf("layer %0d bram add1 pulses", idx), exp_weights * (k % 2),
                    add1_cnt);
        check_count($sformatf("layer %0d bram port selects", idx), exp_weights * (k / 2),
                    psel_cnt);
        output_done_i = 1'b1;
        wait_cycles(1);
        output_done_i = 1'b0;
        check_status($sformatf("layer %0d output done", idx),
                     cu_isa_pkg::ST_OUTPUT_DONE, status_o);
        ctrl0_i = '0;
        wait_cycles(1);
        check_level($sformatf("layer %0d axis enable after finish", idx), 1'b0, axis_en_o);
        check_idle($sformatf("layer %0d after finish", idx));
    endtask

    // FIFO empty about a quarter of the time and BRAM valid three quarters
    initial begin
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #2;
            rng = lcg_step(rng);
            ifmap_fifo_empty_i = (rng[31:30] == 2'b00);
            weight_valid_i     = (rng[29:28] != 2'b00);
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        report_failure("watchdog expired: the DUT hung waiting for a finish or a done strobe");
    end

    initial begin
        int total_pulses;
        rst_n               = 1'b0;
        ctrl0_i             = '0;
        ctrl1_i             = '0;
        ctrl2_i             = '0;
        weight_write_done_i = 1'b0;
        output_done_i       = 1'b0;
        ifmap_fifo_empty_i  = 1'b0;
        weight_valid_i      = 1'b0;
        rng                 = SEED;
        total_pulses        = 1;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            cfg_kernel[i] = 1 + rand_below(5);
            cfg_stride[i] = 1 + rand_below(cfg_kernel[i]);
            cfg_dim[i]    = 2 + rand_below(3);
            cfg_och[i]    = 1 + rand_below(4);
            total_pulses += cfg_dim[i] * cfg_dim[i] * cfg_och[i];
        end
        write_wait      = 4 + rand_below(8);
        watchdog_cycles = 200 * total_pulses + 2000;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait_cycles(1);
        check_idle("after reset");
        check_status("reset status", cu_isa_pkg::ST_CLEAR, status_o);
        check_level("axis enable after reset", 1'b0, axis_en_o);
        run_weight_write();
        run_abort(0);
        for (int i = 0; i < NUM_LAYERS; i++) begin
            run_layer(i);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: list.f
source/cu_isa_pkg.sv
source/cu_state_pkg.sv
source/layer_cfg_if.sv
source/inst_decoder.sv
source/weight_writer.sv
source/ifmap_sequencer.sv
source/weight_loader.sv
source/cu_top.sv
dv/cu_tb.sv

// File: source/cu_isa_pkg.sv
// register map of the control unit, all three control registers are CTRL_W wide
// an opcode value outside opcode_e is read as no instruction
package cu_isa_pkg;

    parameter int CTRL_W = 32;

    typedef enum logic [7:0] {
        OP_WRITE_WEIGHT = 8'd12,
        OP_COMPUTE      = 8'd87
    } opcode_e;

    // status register values seen by the processor
    typedef enum logic [CTRL_W-1:0] {
        ST_CLEAR       = 32'h0000_0000,
        ST_WEIGHT_DONE = 32'h0000_0001,
        ST_OUTPUT_DONE = 32'hFFFF_FFFF
    } status_e;

    ////////////////////////////////////////
    // field positions
    ////////////////////////////////////////

    // ctrl0 holds opcode 7..0, in-channels 19..8 and out-channels 31..20
    parameter int OPC_LSB    = 0;
    parameter int IN_CH_LSB  = 8;
    parameter int OUT_CH_LSB = 20;

    // ctrl1 holds output dimension 10..2 and stride 13..11
    parameter int DIM_LSB    = 2;
    parameter int STRIDE_LSB = 11;

    // ctrl2 holds the one-hot kernel in 4..0
    parameter int KERNEL_LSB = 0;

endpackage

// File: source/cu_state_pkg.sv
// sequencer states and the kernel encoding
// kernel values other than one-hot K1..K5 are treated as K1
package cu_state_pkg;

    typedef enum logic [4:0] {
        K1 = 5'b00001,
        K2 = 5'b00010,
        K3 = 5'b00100,
        K4 = 5'b01000,
        K5 = 5'b10000
    } kernel_e;

    typedef enum logic [2:0] {
        IF_IDLE,
        IF_WAIT_FIRST,
        IF_LOAD_FIRST,
        IF_COMPUTE,
        IF_WAIT_STEP,
        IF_LOAD_STEP
    } ifmap_state_e;

    typedef enum logic [2:0] {
        WL_IDLE,
        WL_RESET_ADDR,
        WL_FETCH,
        WL_SHIFT,
        WL_LOAD_WEIGHT
    } wload_state_e;

    typedef enum logic [1:0] {
        WW_IDLE,
        WW_START,
        WW_WAIT,
        WW_FINISH
    } wwrite_state_e;

    // kernel rows as a count
    function automatic logic [2:0] kernel_rows(kernel_e k);
        case (k)
            K2:      return 3'd2;
            K3:      return 3'd3;
            K4:      return 3'd4;
            K5:      return 3'd5;
            default: return 3'd1;
        endcase
    endfunction

endpackage

// File: source/cu_top.sv
// control unit of the convolution accelerator
// weight writer and weight loader never run together, the opcode picks one
`timescale 1ns/10ps
module cu_top #(
    parameter int CH_BITS  = 12,
    parameter int DIM_BITS = 9
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cu_isa_pkg::CTRL_W-1:0] ctrl0_i,
    input  logic [cu_isa_pkg::CTRL_W-1:0] ctrl1_i,
    input  logic [cu_isa_pkg::CTRL_W-1:0] ctrl2_i,
    input  logic                          weight_write_done_i,
    input  logic                          output_done_i,
    input  logic                          ifmap_fifo_empty_i,
    input  logic                          weight_valid_i,
    output cu_isa_pkg::status_e           status_o,
    output logic                          axis_en_o,
    output logic                          axis_clear_o,
    output logic [CH_BITS-1:0]            in_channels_o,
    output logic                          layer_finish_o,
    output logic                          load_ifmaps_o,
    output logic                          load_weight_preload_o,
    output logic                          load_weight_o,
    output logic                          weight_bram_write_en_o,
    output logic                          weight_bram_write_start_o,
    output logic                          weight_bram_load_start_o,
    output logic                          weight_bram_add1_o,
    output logic                          weight_bram_add2_o,
    output logic                          weight_bram_port_sel_o
);
    logic write_weight_en;
    logic window_ready;
    logic pass_done;

    layer_cfg_if #(
        .CH_BITS  (CH_BITS),
        .DIM_BITS (DIM_BITS)
    ) cfg_if ();

    inst_decoder #(
        .CH_BITS  (CH_BITS),
        .DIM_BITS (DIM_BITS)
    ) i_inst_decoder (
        .clk                 (clk),
        .rst_n               (rst_n),
        .ctrl0_i             (ctrl0_i),
        .ctrl1_i             (ctrl1_i),
        .ctrl2_i             (ctrl2_i),
        .weight_write_done_i (weight_write_done_i),
        .output_done_i       (output_done_i),
        .layer_finish_i      (layer_finish_o),
        .cfg                 (cfg_if.src),
        .write_weight_en_o   (write_weight_en),
        .axis_en_o           (axis_en_o),
        .axis_clear_o        (axis_clear_o),
        .in_channels_o       (in_channels_o),
        .status_o            (status_o)
    );

    weight_writer i_weight_writer (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .write_weight_en_i         (write_weight_en),
        .weight_write_done_i       (weight_write_done_i),
        .weight_bram_write_en_o    (weight_bram_write_en_o),
        .weight_bram_write_start_o (weight_bram_write_start_o)
    );

    ifmap_sequencer #(
        .DIM_BITS (DIM_BITS)
    ) i_ifmap_sequencer (
        .clk                (clk),
        .rst_n              (rst_n),
        .cfg                (cfg_if.sink),
        .ifmap_fifo_empty_i (ifmap_fifo_empty_i),
        .pass_done_i        (pass_done),
        .window_ready_o     (window_ready),
        .load_ifmaps_o      (load_ifmaps_o),
        .layer_finish_o     (layer_finish_o)
    );

    weight_loader #(
        .CH_BITS (CH_BITS)
    ) i_weight_loader (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .cfg                      (cfg_if.sink),
        .window_ready_i           (window_ready),
        .weight_valid_i           (weight_valid_i),
        .pass_done_o              (pass_done),
        .load_weight_preload_o    (load_weight_preload_o),
        .load_weight_o            (load_weight_o),
        .weight_bram_load_start_o (weight_bram_load_start_o),
        .weight_bram_add1_o       (weight_bram_add1_o),
        .weight_bram_add2_o       (weight_bram_add2_o),
        .weight_bram_port_sel_o   (weight_bram_port_sel_o)
    );

endmodule

// File: source/ifmap_sequencer.sv
// steps the ifmap window over the output map; stride must lie in 1..kernel
// after a finished layer it waits for compute_en to drop before it starts again
`timescale 1ns/10ps
module ifmap_sequencer #(
    parameter int DIM_BITS = 9
) (
    input  logic      clk,
    input  logic      rst_n,
    layer_cfg_if.sink cfg,
    input  logic      ifmap_fifo_empty_i,
    input  logic      pass_done_i,
    output logic      window_ready_o,
    output logic      load_ifmaps_o,
    output logic      layer_finish_o
);
    cu_state_pkg::ifmap_state_e state;
    logic [2:0]                 load_cnt;
    logic [DIM_BITS-1:0]        col_cnt;
    logic [DIM_BITS-1:0]        row_cnt;
    logic                       last_col;
    logic                       last_row;
    logic                       window_done;
    logic                       layer_done_q;

    assign last_col    = (col_cnt == cfg.ofmap_dim - DIM_BITS'(1));
    assign last_row    = (row_cnt == cfg.ofmap_dim - DIM_BITS'(1));
    assign window_done = (state == cu_state_pkg::IF_COMPUTE) && pass_done_i;

    assign window_ready_o = (state == cu_state_pkg::IF_COMPUTE);
    assign load_ifmaps_o  = (state == cu_state_pkg::IF_LOAD_FIRST) ||
                            (state == cu_state_pkg::IF_LOAD_STEP);
    assign layer_finish_o = window_done && last_col && last_row;

    ////////////////////////////////////////
    // window FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cu_state_pkg::IF_IDLE;
        end else if (!cfg.compute_en) begin
            state <= cu_state_pkg::IF_IDLE;
        end else begin
            case (state)
                cu_state_pkg::IF_IDLE: begin
                    if (!layer_done_q) begin
                        state <= cu_state_pkg::IF_WAIT_FIRST;
                    end
                end
                cu_state_pkg::IF_WAIT_FIRST: begin
                    if (!ifmap_fifo_empty_i) begin
                        state <= cu_state_pkg::IF_LOAD_FIRST;
                    end
                end
                // one load per kernel row
                cu_state_pkg::IF_LOAD_FIRST: begin
                    if (load_cnt + 3'd1 == cu_state_pkg::kernel_rows(cfg.kernel)) begin
                        state <= cu_state_pkg::IF_COMPUTE;
                    end else begin
                        state <= cu_state_pkg::IF_WAIT_FIRST;
                    end
                end
                cu_state_pkg::IF_COMPUTE: begin
                    if (pass_done_i) begin
                        if (!last_col) begin
                            state <= cu_state_pkg::IF_WAIT_STEP;
                        end else if (!last_row) begin
                            state <= cu_state_pkg::IF_WAIT_FIRST;
                        end else begin
                            state <= cu_state_pkg::IF_IDLE;
                        end
                    end
                end
                cu_state_pkg::IF_WAIT_STEP: begin
                    if (!ifmap_fifo_empty_i) begin
                        state <= cu_state_pkg::IF_LOAD_STEP;
                    end
                end
                cu_state_pkg::IF_LOAD_STEP: begin
                    if (load_cnt + 3'd1 == cfg.stride) begin
                        state <= cu_state_pkg::IF_COMPUTE;
                    end else begin
                        state <= cu_state_pkg::IF_WAIT_STEP;
                    end
                end
                default: begin
                    state <= cu_state_pkg::IF_IDLE;
                end
            endcase
        end
    end

    // load counter restarts in every window, position counters run 0..dim-1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_cnt     <= '0;
            col_cnt      <= '0;
            row_cnt      <= '0;
            layer_done_q <= 1'b0;
        end else begin
            if (load_ifmaps_o) begin
                load_cnt <= load_cnt + 3'd1;
            end else if (window_ready_o || state == cu_state_pkg::IF_IDLE) begin
                load_cnt <= '0;
            end
            if (state == cu_state_pkg::IF_IDLE) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (window_done) begin
                col_cnt <= last_col ? '0 : col_cnt + DIM_BITS'(1);
                row_cnt <= last_col ? row_cnt + DIM_BITS'(1) : row_cnt;
            end
            if (!cfg.compute_en) begin
                layer_done_q <= 1'b0;
            end else if (layer_finish_o) begin
                layer_done_q <= 1'b1;
            end
        end
    end

endmodule

// File: source/inst_decoder.sv
// register decode, stream gating and status; the opcode must stay stable during an instruction
`timescale 1ns/10ps
module inst_decoder #(
    parameter int CH_BITS  = 12,
    parameter int DIM_BITS = 9
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cu_isa_pkg::CTRL_W-1:0] ctrl0_i,
    input  logic [cu_isa_pkg::CTRL_W-1:0] ctrl1_i,
    input  logic [cu_isa_pkg::CTRL_W-1:0] ctrl2_i,
    input  logic                          weight_write_done_i,
    input  logic                          output_done_i,
    input  logic                          layer_finish_i,
    layer_cfg_if.src                      cfg,
    output logic                          write_weight_en_o,
    output logic                          axis_en_o,
    output logic                          axis_clear_o,
    output logic [CH_BITS-1:0]            in_channels_o,
    output cu_isa_pkg::status_e           status_o
);
    logic [7:0] opcode;
    logic       op_compute;
    logic       op_write;
    logic       op_compute_q;
    logic       op_write_q;
    logic       compute_edge;
    logic       any_edge;
    logic       axis_latch;
    logic       axis_clear_q;

    assign opcode     = ctrl0_i[cu_isa_pkg::OPC_LSB +: 8];
    assign op_compute = (opcode == cu_isa_pkg::OP_COMPUTE);
    assign op_write   = (opcode == cu_isa_pkg::OP_WRITE_WEIGHT);

    // layer configuration slices
    assign cfg.compute_en   = op_compute;
    assign cfg.kernel       = cu_state_pkg::kernel_e'(ctrl2_i[cu_isa_pkg::KERNEL_LSB +: 5]);
    assign cfg.stride       = ctrl1_i[cu_isa_pkg::STRIDE_LSB +: 3];
    assign cfg.ofmap_dim    = ctrl1_i[cu_isa_pkg::DIM_LSB +: DIM_BITS];
    assign cfg.out_channels = ctrl0_i[cu_isa_pkg::OUT_CH_LSB +: CH_BITS];
    assign in_channels_o    = ctrl0_i[cu_isa_pkg::IN_CH_LSB +: CH_BITS];

    assign write_weight_en_o = op_write;

    // first cycle of a new opcode
    assign compute_edge = op_compute & ~op_compute_q;
    assign any_edge     = compute_edge | (op_write & ~op_write_q);

    // stream stays open after the opcode until the work drains
    assign axis_en_o    = op_compute | op_write | axis_latch;
    // flush the stream FIFOs before a layer and after a weight write
    assign axis_clear_o = compute_edge | axis_clear_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_compute_q <= 1'b0;
            op_write_q   <= 1'b0;
            axis_clear_q <= 1'b0;
            axis_latch   <= 1'b0;
        end else begin
            op_compute_q <= op_compute;
            op_write_q   <= op_write;
            axis_clear_q <= weight_write_done_i;
            if (layer_finish_i || weight_write_done_i) begin
                axis_latch <= 1'b0;
            end else if (any_edge) begin
                axis_latch <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // status register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_o <= cu_isa_pkg::ST_CLEAR;
        end else if (weight_write_done_i) begin
            status_o <= cu_isa_pkg::ST_WEIGHT_DONE;
        end else if (output_done_i) begin
            status_o <= cu_isa_pkg::ST_OUTPUT_DONE;
        end else if (any_edge) begin
            status_o <= cu_isa_pkg::ST_CLEAR;
        end
    end

endmodule

// File: source/layer_cfg_if.sv
// decoded layer configuration, valid only while compute_en is high
`timescale 1ns/10ps
interface layer_cfg_if #(
    parameter int CH_BITS  = 12,
    parameter int DIM_BITS = 9
);
    logic                  compute_en;
    cu_state_pkg::kernel_e kernel;
    logic [2:0]            stride;
    logic [DIM_BITS-1:0]   ofmap_dim;
    logic [CH_BITS-1:0]    out_channels;

    modport src (
        output compute_en, kernel, stride, ofmap_dim, out_channels
    );

    modport sink (
        input compute_en, kernel, stride, ofmap_dim, out_channels
    );

endinterface

// File: source/weight_loader.sv
// reads every filter of a window from the dual-port weight BRAM in word pairs
// port A gives the first word of a pair, port B the second
`timescale 1ns/10ps
module weight_loader #(
    parameter int CH_BITS = 12
) (
    input  logic      clk,
    input  logic      rst_n,
    layer_cfg_if.sink cfg,
    input  logic      window_ready_i,
    input  logic      weight_valid_i,
    output logic      pass_done_o,
    output logic      load_weight_preload_o,
    output logic      load_weight_o,
    output logic      weight_bram_load_start_o,
    output logic      weight_bram_add1_o,
    output logic      weight_bram_add2_o,
    output logic      weight_bram_port_sel_o
);
    cu_state_pkg::wload_state_e state;
    logic [2:0]                 word_cnt;
    logic [CH_BITS-1:0]         filter_cnt;
    logic                       fetch_hit;
    logic                       word_step;
    logic                       last_word;
    logic                       last_filter;

    assign fetch_hit   = (state == cu_state_pkg::WL_FETCH) && weight_valid_i;
    assign word_step   = fetch_hit || (state == cu_state_pkg::WL_SHIFT);
    assign last_word   = (word_cnt + 3'd1 == cu_state_pkg::kernel_rows(cfg.kernel));
    assign last_filter = (filter_cnt + CH_BITS'(1) == cfg.out_channels);

    assign pass_done_o              = (state == cu_state_pkg::WL_LOAD_WEIGHT) && last_filter;
    assign weight_bram_load_start_o = (state == cu_state_pkg::WL_RESET_ADDR);
    assign weight_bram_port_sel_o   = (state == cu_state_pkg::WL_SHIFT);
    // advance by two after a pair, by one after an odd last word
    assign weight_bram_add2_o       = (state == cu_state_pkg::WL_SHIFT);
    assign weight_bram_add1_o       = fetch_hit && last_word;

    ////////////////////////////////////////
    // read FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cu_state_pkg::WL_IDLE;
        end else if (!cfg.compute_en) begin
            state <= cu_state_pkg::WL_IDLE;
        end else begin
            case (state)
                cu_state_pkg::WL_IDLE: begin
                    if (window_ready_i) begin
                        state <= cu_state_pkg::WL_RESET_ADDR;
                    end
                end
                cu_state_pkg::WL_RESET_ADDR: begin
                    state <= cu_state_pkg::WL_FETCH;
                end
                cu_state_pkg::WL_FETCH: begin
                    if (weight_valid_i) begin
                        state <= last_word ? cu_state_pkg::WL_LOAD_WEIGHT
                                           : cu_state_pkg::WL_SHIFT;
                    end
                end
                cu_state_pkg::WL_SHIFT: begin
                    state <= last_word ? cu_state_pkg::WL_LOAD_WEIGHT
                                       : cu_state_pkg::WL_FETCH;
                end
                cu_state_pkg::WL_LOAD_WEIGHT: begin
                    state <= last_filter ? cu_state_pkg::WL_IDLE : cu_state_pkg::WL_FETCH;
                end
                default: begin
                    state <= cu_state_pkg::WL_IDLE;
                end
            endcase
        end
    end

    // word count per filter, filter count per window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt              <= '0;
            filter_cnt            <= '0;
            load_weight_preload_o <= 1'b0;
            load_weight_o         <= 1'b0;
        end else begin
            if (word_step) begin
                word_cnt <= word_cnt + 3'd1;
            end else if (state != cu_state_pkg::WL_FETCH) begin
                word_cnt <= '0;
            end
            if (state == cu_state_pkg::WL_IDLE) begin
                filter_cnt <= '0;
            end else if (state == cu_state_pkg::WL_LOAD_WEIGHT) begin
                filter_cnt <= filter_cnt + CH_BITS'(1);
            end
            // one preload per kernel row, one load per filter
            load_weight_preload_o <= cfg.compute_en && word_step;
            load_weight_o         <= cfg.compute_en && (state == cu_state_pkg::WL_LOAD_WEIGHT);
        end
    end

endmodule

// File: source/weight_writer.sv
// weight BRAM write control, parks in FINISH until the opcode is withdrawn
`timescale 1ns/10ps
module weight_writer (
    input  logic clk,
    input  logic rst_n,
    input  logic write_weight_en_i,
    input  logic weight_write_done_i,
    output logic weight_bram_write_en_o,
    output logic weight_bram_write_start_o
);
    cu_state_pkg::wwrite_state_e state;

    assign weight_bram_write_start_o = (state == cu_state_pkg::WW_START);
    assign weight_bram_write_en_o    = (state != cu_state_pkg::WW_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cu_state_pkg::WW_IDLE;
        end else if (!write_weight_en_i) begin
            state <= cu_state_pkg::WW_IDLE;
        end else begin
            case (state)
                cu_state_pkg::WW_IDLE: begin
                    state <= cu_state_pkg::WW_START;
                end
                cu_state_pkg::WW_START: begin
                    state <= cu_state_pkg::WW_WAIT;
                end
                // BRAM controller streams all weights in here
                cu_state_pkg::WW_WAIT: begin
                    if (weight_write_done_i) begin
                        state <= cu_state_pkg::WW_FINISH;
                    end
                end
                cu_state_pkg::WW_FINISH: begin
                    state <= cu_state_pkg::WW_FINISH;
                end
                default: begin
                    state <= cu_state_pkg::WW_IDLE;
                end
            endcase
        end
    end

endmodule
